// ==== cpuPkg.sv ====
package cpuPkg;

    // accumulator, memory word and instruction width
    typedef logic [15:0] dataWord;

    // word address into main memory
    typedef logic [7:0] memAddr;

    // alu operation select
    typedef logic [3:0] aluOpCode;

    // instruction class field
    typedef logic [3:0] opClass;

    // main memory depth
    localparam int memWords = 256;

    // arithmetic
    localparam aluOpCode aluAdd  = 4'd0;
    localparam aluOpCode aluSub  = 4'd1;
    localparam aluOpCode aluMul  = 4'd2;
    localparam aluOpCode aluDiv  = 4'd3;
    // shifts and rotates by one place
    localparam aluOpCode aluShl  = 4'd4;
    localparam aluOpCode aluShr  = 4'd5;
    localparam aluOpCode aluRol  = 4'd6;
    localparam aluOpCode aluRor  = 4'd7;
    // bitwise
    localparam aluOpCode aluAnd  = 4'd8;
    localparam aluOpCode aluOr   = 4'd9;
    localparam aluOpCode aluXor  = 4'd10;
    localparam aluOpCode aluNor  = 4'd11;
    localparam aluOpCode aluNand = 4'd12;
    localparam aluOpCode aluXnor = 4'd13;
    // compares, result is 1 or 0
    localparam aluOpCode aluGt   = 4'd14;
    localparam aluOpCode aluEq   = 4'd15;

    // instruction classes, unlisted codes act as no-op
    localparam opClass classLoad     = 4'd0;
    localparam opClass classStore    = 4'd1;
    localparam opClass classAlu      = 4'd2;
    localparam opClass classJump     = 4'd3;
    localparam opClass classJumpZero = 4'd4;
    localparam opClass classHalt     = 4'd15;

    // instruction word layout, msb first
    typedef struct packed {
        opClass   instrClass;
        aluOpCode aluOp;
        memAddr   operand;
    } instrFields;

    // core side memory access
    typedef struct packed {
        memAddr  addr;
        dataWord writeData;
        logic    write;
    } memRequest;

    // reported with every store
    typedef struct packed {
        memAddr  addr;
        dataWord value;
    } storeEvent;

endpackage

// ==== alu.sv ====
module alu (
    input  cpuPkg::aluOpCode opCode,
    input  cpuPkg::dataWord  operandA,
    input  cpuPkg::dataWord  operandB,
    output cpuPkg::dataWord  result
);

    import cpuPkg::*;

    // purely combinational, every one of the 16 codes is decoded
    always_comb begin
        case (opCode)
            aluAdd: begin
                result = operandA + operandB;
            end
            aluSub: begin
                result = operandA - operandB;
            end
            aluMul: begin
                // 16 bit context keeps the low half of the product
                result = operandA * operandB;
            end
            aluDiv: begin
                // divide by zero saturates to all ones
                if (operandB == '0) begin
                    result = '1;
                end else begin
                    result = operandA / operandB;
                end
            end
            // single place shifts, operandB unused here
            aluShl: begin
                result = {operandA[14:0], 1'b0};
            end
            aluShr: begin
                result = {1'b0, operandA[15:1]};
            end
            aluRol: begin
                result = {operandA[14:0], operandA[15]};
            end
            aluRor: begin
                result = {operandA[0], operandA[15:1]};
            end
            aluAnd: begin
                result = operandA & operandB;
            end
            aluOr: begin
                result = operandA | operandB;
            end
            aluXor: begin
                result = operandA ^ operandB;
            end
            aluNor: begin
                result = ~(operandA | operandB);
            end
            aluNand: begin
                result = ~(operandA & operandB);
            end
            aluXnor: begin
                result = ~(operandA ^ operandB);
            end
            // unsigned compares
            aluGt: begin
                result = (operandA > operandB) ? 16'd1 : 16'd0;
            end
            aluEq: begin
                result = (operandA == operandB) ? 16'd1 : 16'd0;
            end
        endcase
    end

endmodule

// ==== mainMemory.sv ====
module mainMemory (
    input  logic               clock,
    input  logic               arstN,
    input  logic               hostWrite,
    input  cpuPkg::memAddr     hostAddr,
    input  cpuPkg::dataWord    hostData,
    input  logic               coreActive,
    input  cpuPkg::memRequest  coreRequest,
    output cpuPkg::dataWord    readData
);

    import cpuPkg::*;

    // word storage
    dataWord memArray [memWords];

    // single write port, shared between host and core
    logic    writeEnable;
    memAddr  writeAddr;
    dataWord writeValue;

    // owner of the write port follows coreActive
    always_comb begin
        if (coreActive) begin
            writeEnable = coreRequest.write;
            writeAddr   = coreRequest.addr;
            writeValue  = coreRequest.writeData;
        end else begin
            // host loads program and data only while the core is idle
            writeEnable = hostWrite;
            writeAddr   = hostAddr;
            writeValue  = hostData;
        end
    end

    always_ff @(posedge clock) begin
        if (writeEnable) begin
            memArray[writeAddr] <= writeValue;
        end
    end

    // registered read, data one cycle after the address
    // a same cycle write returns the old word
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            readData <= '0;
        end else if (coreActive) begin
            readData <= memArray[coreRequest.addr];
        end
    end

    // host must not touch memory while a program runs
    hostIdleOnly: assert property (
        @(posedge clock) disable iff (!arstN)
        coreActive |-> !hostWrite
    ) else $error("host write while core is active");

endmodule

// ==== cpuCore.sv ====
module cpuCore (
    input  logic               clock,
    input  logic               arstN,
    input  logic               start,
    input  cpuPkg::dataWord    readData,
    output cpuPkg::memRequest  coreRequest,
    output logic               busy,
    output logic               halted,
    output logic               storeStrobe,
    output cpuPkg::storeEvent  storeInfo,
    output cpuPkg::dataWord    accumulator
);

    import cpuPkg::*;

    // one instruction takes fetch, decode, operand, execute
    typedef enum logic [2:0] {
        stIdle,
        stFetch,
        stDecode,
        stOperand,
        stExecute,
        stHalt
    } coreState;

    coreState   state;

    // program counter, wraps 255 to 0
    memAddr     pc;
    // instruction register
    instrFields ir;
    // memory buffer register
    dataWord    mbr;

    // word arriving from memory, seen as an instruction in decode
    instrFields fetched;
    dataWord    aluResult;

    assign fetched = instrFields'(readData);

    // operand word is the buffer input during execute,
    // so the alu result lands on the same edge as the buffer load
    alu i_alu (
        .opCode   (ir.aluOp),
        .operandA (accumulator),
        .operandB (readData),
        .result   (aluResult)
    );

    // memory address and write control
    always_comb begin
        coreRequest.addr      = pc;
        coreRequest.writeData = mbr;
        coreRequest.write     = 1'b0;
        if (state == stOperand) begin
            // operand phase addresses the operand field
            coreRequest.addr  = ir.operand;
            coreRequest.write = (ir.instrClass == classStore);
        end
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            state       <= stIdle;
            pc          <= '0;
            ir          <= '0;
            mbr         <= '0;
            accumulator <= '0;
            busy        <= 1'b0;
            halted      <= 1'b0;
            storeStrobe <= 1'b0;
            storeInfo   <= '0;
        end else begin
            // strobe lasts exactly one cycle
            storeStrobe <= 1'b0;

            case (state)
                stIdle, stHalt: begin
                    // start runs from address 0, halted clears here
                    if (start) begin
                        state  <= stFetch;
                        pc     <= '0;
                        busy   <= 1'b1;
                        halted <= 1'b0;
                    end
                end

                stFetch: begin
                    // address is pc, word comes back next cycle
                    state <= stDecode;
                end

                stDecode: begin
                    ir    <= fetched;
                    pc    <= pc + memAddr'(1);
                    state <= stOperand;
                    // store data and event prepared for the operand cycle
                    if (fetched.instrClass == classStore) begin
                        mbr         <= accumulator;
                        storeStrobe <= 1'b1;
                        storeInfo   <= '{addr: fetched.operand, value: accumulator};
                    end
                end

                stOperand: begin
                    // store writes now, every other class reads its operand
                    state <= stExecute;
                end

                stExecute: begin
                    mbr   <= readData;
                    state <= stFetch;
                    case (ir.instrClass)
                        classLoad: begin
                            accumulator <= readData;
                        end
                        classAlu: begin
                            accumulator <= aluResult;
                        end
                        classJump: begin
                            pc <= ir.operand;
                        end
                        classJumpZero: begin
                            // taken on a zero accumulator only
                            if (accumulator == '0) begin
                                pc <= ir.operand;
                            end
                        end
                        classHalt: begin
                            state  <= stHalt;
                            busy   <= 1'b0;
                            halted <= 1'b1;
                        end
                        default: begin
                            // store already done, unknown classes are no-ops
                            accumulator <= accumulator;
                        end
                    endcase
                end

                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // registered strobe must line up with the operand write
    strobeInOperand: assert property (
        @(posedge clock) disable iff (!arstN)
        storeStrobe |-> (state == stOperand) && coreRequest.write
    ) else $error("store strobe outside operand cycle");

    // a running core never reports halted
    busyHaltExclusive: assert property (
        @(posedge clock) disable iff (!arstN)
        !(busy && halted)
    ) else $error("busy and halted both high");

endmodule

// ==== computer.sv ====
module computer (
    input  logic               clock,
    input  logic               arstN,
    input  logic               hostWrite,
    input  cpuPkg::memAddr     hostAddr,
    input  cpuPkg::dataWord    hostData,
    input  logic               start,
    output logic               busy,
    output logic               halted,
    output logic               storeStrobe,
    output cpuPkg::storeEvent  storeInfo,
    output cpuPkg::dataWord    accumulator
);

    import cpuPkg::*;

    // core to memory
    memRequest coreRequest;
    // memory to core, one cycle after the address
    dataWord   readData;

    // sequencer with its registers and the alu
    cpuCore i_cpuCore (
        .clock       (clock),
        .arstN       (arstN),
        .start       (start),
        .readData    (readData),
        .coreRequest (coreRequest),
        .busy        (busy),
        .halted      (halted),
        .storeStrobe (storeStrobe),
        .storeInfo   (storeInfo),
        .accumulator (accumulator)
    );

    // busy hands the memory ports to the core
    mainMemory i_mainMemory (
        .clock       (clock),
        .arstN       (arstN),
        .hostWrite   (hostWrite),
        .hostAddr    (hostAddr),
        .hostData    (hostData),
        .coreActive  (busy),
        .coreRequest (coreRequest),
        .readData    (readData)
    );

endmodule

// ==== tbComputer.sv ====
module tbComputer;

    timeunit 1ns;
    timeprecision 1ps;

    import cpuPkg::*;

    localparam int clockPeriod = 8;
    localparam int maxCases    = 16;

    logic      clock;
    logic      arstN;
    logic      hostWrite;
    memAddr    hostAddr;
    dataWord   hostData;
    logic      start;
    logic      busy;
    logic      halted;
    logic      storeStrobe;
    storeEvent storeInfo;
    dataWord   accumulator;

    // program words and expected stores of all cases, back to back
    memAddr  progAddr[$];
    dataWord progWord[$];
    memAddr  storeAddr[$];
    dataWord storeValue[$];
    // end index of each case in the queues above
    int      progEnd[maxCases];
    int      storeEnd[maxCases];
    dataWord expAcc[maxCases];
    int      maxInstr[maxCases];
    int      caseCount = 0;

    int      errorCount = 0;
    int      seed = 60265;
    // window of stores expected from the running program
    int      storeNext = 0;
    int      storeLimit = 0;
    realtime watchdogTime = 0.0;

    computer i_computer (
        .clock       (clock),
        .arstN       (arstN),
        .hostWrite   (hostWrite),
        .hostAddr    (hostAddr),
        .hostData    (hostData),
        .start       (start),
        .busy        (busy),
        .halted      (halted),
        .storeStrobe (storeStrobe),
        .storeInfo   (storeInfo),
        .accumulator (accumulator)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(clockPeriod / 2) clock = ~clock;
        end
    end

    task automatic reportMismatch(input string name, input dataWord expected,
                                  input dataWord actual);
        $display("Fail at %0d ns: %s expected %h, actual %h", $time, name, expected, actual);
        errorCount++;
    endtask

    task automatic reportError(input string what);
        $display("Error at %0d ns: %s", $time, what);
        errorCount++;
    endtask

    task automatic finishRun();
        $display("%0d errors over %0d cases", errorCount, caseCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic readCases();
        int    fileHandle;
        int    fieldCount;
        int    first;
        int    second;
        int    cycles;
        string line;
        fileHandle = $fopen("computer_cases.txt", "r");
        if (fileHandle == 0) begin
            reportError("cannot open computer_cases.txt");
        end else begin
            while (!$feof(fileHandle)) begin
                line = "";
                fieldCount = $fgets(line, fileHandle);
                // comment and blank lines fall to the default
                if (fieldCount > 0) begin
                    case (line[0])
                        "P": begin
                            fieldCount = $sscanf(line, "P %h %h", first, second);
                            progAddr.push_back(memAddr'(first));
                            progWord.push_back(dataWord'(second));
                        end
                        "S": begin
                            fieldCount = $sscanf(line, "S %h %h", first, second);
                            storeAddr.push_back(memAddr'(first));
                            storeValue.push_back(dataWord'(second));
                        end
                        "A": begin
                            fieldCount = $sscanf(line, "A %h", first);
                            expAcc[caseCount] = dataWord'(first);
                        end
                        "R": begin
                            // closes the block of one case
                            fieldCount = $sscanf(line, "R %d", first);
                            maxInstr[caseCount] = first;
                            progEnd[caseCount]  = progAddr.size();
                            storeEnd[caseCount] = storeAddr.size();
                            caseCount++;
                        end
                        default: begin
                        end
                    endcase
                end
            end
            $fclose(fileHandle);
        end
        // four cycles per instruction, plus loads, idle gap and start per case
        cycles = progAddr.size();
        for (int c = 0; c < caseCount; c++)
            cycles += maxInstr[c] * 4 + 16;
        watchdogTime = cycles * clockPeriod + 1000.0;
    endtask

    task automatic runCase(input int c);
        int   gap;
        time  startTime;
        logic strayDone;
        // host port loads program and data while the core is idle
        for (int i = (c == 0) ? 0 : progEnd[c - 1]; i < progEnd[c]; i++) begin
            @(posedge clock);
            hostWrite <= 1'b1;
            hostAddr  <= progAddr[i];
            hostData  <= progWord[i];
        end
        @(posedge clock);
        hostWrite <= 1'b0;
        gap = $unsigned($random(seed)) % 8;
        repeat (gap) @(posedge clock);
        storeNext  = (c == 0) ? 0 : storeEnd[c - 1];
        storeLimit = storeEnd[c];
        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
        // first fetch cycle, old halted must be gone
        @(negedge clock);
        startTime = $time;
        if (busy !== 1'b1)
            reportMismatch("busy", 16'd1, busy);
        if (halted !== 1'b0)
            reportMismatch("halted", 16'd0, halted);
        strayDone = 1'b0;
        while (halted !== 1'b1 && $time - startTime < maxInstr[c] * 4 * clockPeriod) begin
            @(negedge clock);
            if (halted !== 1'b1 && busy !== 1'b1)
                reportError($sformatf("case %0d: busy fell before halted rose", c));
            // a restart from this stray start would repeat the first store
            if (!strayDone && storeStrobe === 1'b1) begin
                @(posedge clock);
                start <= 1'b1;
                @(posedge clock);
                start <= 1'b0;
                strayDone = 1'b1;
            end
        end
        if (halted !== 1'b1)
            reportError($sformatf("case %0d: no halt within %0d instructions", c, maxInstr[c]));
        if (busy !== 1'b0)
            reportMismatch("busy", 16'd0, busy);
        if (accumulator !== expAcc[c])
            reportMismatch("accumulator", expAcc[c], accumulator);
        if (storeNext != storeLimit)
            reportError($sformatf("case %0d: %0d expected stores missing", c,
                                  storeLimit - storeNext));
    endtask

    // each store compared with the next one expected, in order
    always @(negedge clock) begin
        if (storeStrobe === 1'b1) begin
            if (storeNext >= storeLimit) begin
                reportError($sformatf("unexpected store of %h to address %h",
                                      storeInfo.value, storeInfo.addr));
            end else begin
                if (storeInfo.addr !== storeAddr[storeNext])
                    reportMismatch("storeInfo.addr", storeAddr[storeNext], storeInfo.addr);
                if (storeInfo.value !== storeValue[storeNext])
                    reportMismatch("storeInfo.value", storeValue[storeNext], storeInfo.value);
                storeNext++;
            end
        end
    end

    initial begin
        wait (watchdogTime > 0.0);
        #(watchdogTime);
        reportError("watchdog expired before all cases finished");
        finishRun();
    end

    initial begin
        int caseIndex;
        arstN     = 1'b0;
        hostWrite = 1'b0;
        hostAddr  = '0;
        hostData  = '0;
        start     = 1'b0;
        readCases();
        repeat (3) @(posedge clock);
        arstN <= 1'b1;
        // outputs straight after reset
        @(negedge clock);
        if (busy !== 1'b0)
            reportMismatch("busy", 16'd0, busy);
        if (halted !== 1'b0)
            reportMismatch("halted", 16'd0, halted);
        if (accumulator !== '0)
            reportMismatch("accumulator", 16'd0, accumulator);
        // every case after the first reruns from halt with a new program
        for (caseIndex = 0; caseIndex < caseCount; caseIndex++)
            runCase(caseIndex);
        finishRun();
    end

endmodule

// ==== computer_cases.txt ====
# P addr word = program word, S addr value = expected store in order (hex)
# A value = final accumulator (hex), R maxInstructions = ends the case (decimal)
# load a word, store it elsewhere, halt
P 00 0040
P 01 1041
P 02 F000
P 40 BEEF
S 41 BEEF
A BEEF
R 3
# all sixteen alu operations chained on the accumulator, result stored after each
P 00 0040
P 01 2041
P 02 1050
P 03 2140
P 04 1050
P 05 2243
P 06 1050
P 07 2341
P 08 1050
P 09 2740
P 0A 1050
P 0B 2640
P 0C 1050
P 0D 2440
P 0E 1050
P 0F 2540
P 10 1050
P 11 2342
P 12 1050
P 13 2843
P 14 1050
P 15 2941
P 16 1050
P 17 2A40
P 18 1050
P 19 2B43
P 1A 1050
P 1B 2C40
P 1C 1050
P 1D 2D43
P 1E 1050
P 1F 2E40
P 20 1050
P 21 2F41
P 22 1050
P 23 F000
P 40 1234
P 41 0005
P 42 0000
P 43 F0F0
S 50 1239
S 50 0005
S 50 B4B0
S 50 2423
S 50 9211
S 50 2423
S 50 4846
S 50 2423
S 50 FFFF
S 50 F0F0
S 50 F0F5
S 50 E2C1
S 50 0D0E
S 50 FFFB
S 50 F0F4
S 50 0001
S 50 0000
A 0000
R 38
# jump over a store, then count down with jump if zero
P 00 0020
P 01 3003
P 02 1030
P 03 1021
P 04 2122
P 05 4007
P 06 3003
P 07 F000
P 20 0003
P 22 0001
S 21 0003
S 21 0002
S 21 0001
A 0000
R 16

// ==== build.f ====
cpuPkg.sv
alu.sv
mainMemory.sv
cpuCore.sv
computer.sv
tbComputer.sv

// ==== Bender.yml ====
package:
  name: computer

sources:
  - cpuPkg.sv
  - alu.sv
  - mainMemory.sv
  - cpuCore.sv
  - computer.sv
  - target: test
    files:
      - tbComputer.sv
